/* design/immu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Instruction MMU shared definitions
// Sizes, TLB word layouts, fetch and register write records
// ~~~~~~~~~~~~~~~~~~~~
package immu_pkg;

   // Virtual address width
   localparam int aw = 32;

   // TLB word width, one machine register
   localparam int dw = 32;

   // Page offset width, 8 KB pages
   localparam int page_bits = 13;

   // Page number width, same for virtual and physical side
   localparam int vpn_w = aw - page_bits;

   // TLB index width
   // Has to stay no greater than vpn_w, index comes from the low vpn bits
   localparam int set_bits = 4;

   // Entries per TLB array
   localparam int n_sets = 1 << set_bits;

   // Page number and TLB index
   typedef logic [vpn_w-1:0] vpn_t;
   typedef logic [set_bits-1:0] idx_t;

   // TLB low word, tag and valid
   typedef struct packed {
      vpn_t        tag;
      logic [11:0] rsv;
      logic        v;
   } tlb_lo_t;

   // TLB high word, translation and permissions
   typedef struct packed {
      vpn_t       ppn;
      logic [3:0] rsv_hi;
      logic       s;
      logic [2:0] rsv_mid;
      logic       rx;
      logic       ux;
      logic [1:0] rsv_lo;
      logic       p;
   } tlb_hi_t;

   // Processor status bits seen by the fetch MMU
   typedef struct packed {
      logic imme;
      logic rm;
   } psr_t;

   // Lookup result back to fetch
   typedef struct packed {
      vpn_t ppn;
      logic eitm;
      logic eipf;
   } fetch_rsp_t;

   // Which TLB word a register write targets
   typedef enum logic {
      msr_tlbl = 1'b0,
      msr_tlbh = 1'b1
   } msr_op_e;

   // Register write request, held stable through the handshake
   typedef struct packed {
      msr_op_e         op;
      idx_t            idx;
      logic [dw-1:0]   data;
   } msr_req_t;

   // Write port handshake states
   typedef enum logic {
      port_idle = 1'b0,
      port_ack  = 1'b1
   } port_state_e;

endpackage

/* design/itlb_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~
// ITLB word array
// Direct mapped, one write port, registered read-first read port
// ~~~~~~~~~~~~~~~~~~~~
module itlb_ram
   import immu_pkg::*;
(
   input  logic          clk,
   // Lookup side
   input  logic          re,
   input  idx_t          raddr,
   output logic [dw-1:0] rdata,
   // Software fill side
   input  logic          we,
   input  idx_t          waddr,
   input  logic [dw-1:0] wdata
);

   // Entry storage
   // Software fills every entry before the MMU is turned on
   logic [dw-1:0] mem [n_sets];

   // Fill from the register write port
   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[waddr] <= wdata;
      end
   end

   // Read register loads only on re
   // Holds the last word while fetch is stalled
   // Same-index write in the same cycle returns the old word
   always_ff @(posedge clk)
   begin
      if (re)
      begin
         rdata <= mem[raddr];
      end
   end

endmodule

/* design/itlb_msr_port.sv */
// ~~~~~~~~~~~~~~~~~~~~
// ITLB register write port
// Four-phase req/ack slave, one TLBL or TLBH strobe per handshake
// ~~~~~~~~~~~~~~~~~~~~
module itlb_msr_port
   import immu_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   // Requester side
   input  logic          msr_req,
   input  msr_req_t      msr,
   output logic          msr_ack,
   // TLB array side
   output logic          lo_we,
   output logic          hi_we,
   output idx_t          wr_idx,
   output logic [dw-1:0] wr_data
);

   port_state_e state_q;
   port_state_e state_d;
   logic        accept;

   // Request taken only from idle
   // Port leaves idle on the same edge, so this fires once per handshake
   assign accept = (state_q == port_idle) && msr_req;

   // Next state
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         port_idle:
         begin
            // Write goes out on the way into port_ack
            if (msr_req)
            begin
               state_d = port_ack;
            end
         end
         port_ack:
         begin
            // Slow requester just keeps us here, no further writes
            if (!msr_req)
            begin
               state_d = port_idle;
            end
         end
      endcase
   end

   // State register
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state_q <= port_idle;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   // Ack follows state, low after reset
   // Drops the cycle after req is seen low
   assign msr_ack = (state_q == port_ack);

   // Strobe select by opcode
   assign lo_we = accept && (msr.op == msr_tlbl);
   assign hi_we = accept && (msr.op == msr_tlbh);

   // Index and data stable for the whole handshake
   assign wr_idx  = msr.idx;
   assign wr_data = msr.data;

endmodule

/* design/immu.sv */
// ~~~~~~~~~~~~~~~~~~~~
// ITLB lookup
// Tag compare, execute permission check, ppn and exception flags
// ~~~~~~~~~~~~~~~~~~~~
module immu
   import immu_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   // Fetch request
   input  logic       re,
   input  vpn_t       vpn,
   input  psr_t       psr,
   // TLB arrays
   output idx_t       rd_idx,
   input  tlb_lo_t    lo_word,
   input  tlb_hi_t    hi_word,
   // Fetch response
   output fetch_rsp_t rsp
);

   // Request state captured with the array read
   psr_t psr_q;
   vpn_t vpn_q;

   // Lookup terms
   logic miss;
   logic denied;
   logic root_deny;
   logic user_deny;

   // Array index straight from the incoming vpn
   // Array word and vpn_q then arrive in the same cycle
   assign rd_idx = vpn[set_bits-1:0];

   // Capture on re only, so stalls keep the last lookup
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         psr_q <= '0;
         vpn_q <= '0;
      end
      else if (re)
      begin
         psr_q <= psr;
         vpn_q <= vpn;
      end
   end

   // Invalid entry or tag mismatch
   assign miss = !(lo_word.v && (lo_word.tag == vpn_q));

   // Root mode checks rx
   assign root_deny = psr_q.rm && !hi_word.rx;

   // User mode checks ux
   assign user_deny = !psr_q.rm && !hi_word.ux;

   // Only the current mode's bit counts
   assign denied = root_deny || user_deny;

   // Response
   always_comb
   begin
      rsp = '0;

      // Miss exception, only with translation on
      rsp.eitm = psr_q.imme && miss;

      // Page fault needs a hit, a miss takes priority
      // Keeps eitm and eipf exclusive
      rsp.eipf = psr_q.imme && denied && !miss;

      // Translated page or pass-through when disabled
      if (psr_q.imme)
      begin
         rsp.ppn = hi_word.ppn;
      end
      else
      begin
         rsp.ppn = vpn_q;
      end
   end

endmodule

/* design/immu_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Instruction MMU top
// Write port, TLB low and high arrays, lookup block
// ~~~~~~~~~~~~~~~~~~~~
module immu_top
   import immu_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   // Fetch side
   input  logic       re,
   input  vpn_t       vpn,
   input  psr_t       psr,
   output fetch_rsp_t rsp,
   // Machine register write side
   input  logic       msr_req,
   input  msr_req_t   msr,
   output logic       msr_ack
);

   // Write port to arrays
   logic          lo_we;
   logic          hi_we;
   idx_t          wr_idx;
   logic [dw-1:0] wr_data;

   // Lookup to arrays
   idx_t          rd_idx;
   logic [dw-1:0] lo_rdata;
   logic [dw-1:0] hi_rdata;

   // Four-phase register write slave
   itlb_msr_port msr_port_i (
      .clk     (clk),
      .reset   (reset),
      .msr_req (msr_req),
      .msr     (msr),
      .msr_ack (msr_ack),
      .lo_we   (lo_we),
      .hi_we   (hi_we),
      .wr_idx  (wr_idx),
      .wr_data (wr_data)
   );

   // Tag and valid words
   itlb_ram tlb_lo_i (
      .clk   (clk),
      .re    (re),
      .raddr (rd_idx),
      .rdata (lo_rdata),
      .we    (lo_we),
      .waddr (wr_idx),
      .wdata (wr_data)
   );

   // Permission and ppn words
   itlb_ram tlb_hi_i (
      .clk   (clk),
      .re    (re),
      .raddr (rd_idx),
      .rdata (hi_rdata),
      .we    (hi_we),
      .waddr (wr_idx),
      .wdata (wr_data)
   );

   // Lookup, raw array words viewed through the entry layouts
   immu immu_i (
      .clk     (clk),
      .reset   (reset),
      .re      (re),
      .vpn     (vpn),
      .psr     (psr),
      .rd_idx  (rd_idx),
      .lo_word (tlb_lo_t'(lo_rdata)),
      .hi_word (tlb_hi_t'(hi_rdata)),
      .rsp     (rsp)
   );

endmodule

/* tb/immu_assert.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Instruction MMU assertions
// Exception flags, write strobes, req/ack protocol
// ~~~~~~~~~~~~~~~~~~~~
module immu_assert
   import immu_pkg::*;
(
   input logic       clk,
   input logic       reset,
   input logic       msr_req,
   input logic       msr_ack,
   input logic       lo_we,
   input logic       hi_we,
   input fetch_rsp_t rsp
);

   // Miss wins over page fault
   flags_excl: assert property (@(posedge clk) disable iff (reset) !(rsp.eitm && rsp.eipf))
      else $error("eitm and eipf high together");

   // Ack only answers a live request
   // Requester may drop req as soon as it sees ack
   ack_rise: assert property (@(posedge clk) disable iff (reset)
                              $rose(msr_ack) |-> $past(msr_req))
      else $error("msr_ack rose without msr_req");

   // One array per write
   we_excl: assert property (@(posedge clk) disable iff (reset) !(lo_we && hi_we))
      else $error("lo_we and hi_we high together");

   // Single-cycle strobe per handshake
   we_pulse: assert property (@(posedge clk) disable iff (reset)
                              (lo_we || hi_we) |=> !(lo_we || hi_we))
      else $error("write strobe longer than one cycle");

endmodule

bind immu_top immu_assert immu_assert_i (
   .clk     (clk),
   .reset   (reset),
   .msr_req (msr_req),
   .msr_ack (msr_ack),
   .lo_we   (lo_we),
   .hi_we   (hi_we),
   .rsp     (rsp)
);

/* tb/immu_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Instruction MMU testbench
// Random TLB fills and lookups checked against a reference TLB
// ~~~~~~~~~~~~~~~~~~~~
module immu_tb
   import immu_pkg::*;
;

   logic       clk;
   logic       reset;
   logic       re;
   vpn_t       vpn;
   psr_t       psr;
   fetch_rsp_t rsp;
   logic       msr_req;
   msr_req_t   msr;
   logic       msr_ack;

   // Reference TLB, updated when a write handshake completes
   tlb_lo_t lo_m [n_sets];
   tlb_hi_t hi_m [n_sets];

   // How often each translation outcome came up
   int n_hit;
   int n_miss;
   int n_fault;
   int n_off;

   immu_top dut_i (
      .clk     (clk),
      .reset   (reset),
      .re      (re),
      .vpn     (vpn),
      .psr     (psr),
      .rsp     (rsp),
      .msr_req (msr_req),
      .msr     (msr),
      .msr_ack (msr_ack)
   );

   always #2 clk = ~clk;

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1);
   endtask

   function automatic logic [31:0] rand_word();
      return $urandom;
   endfunction

   function automatic vpn_t rand_vpn();
      logic [31:0] r;
      r = $urandom;
      return r[vpn_w-1:0];
   endfunction

   function automatic psr_t rand_psr();
      logic [31:0] r;
      psr_t        p;
      r = $urandom;
      p.imme = r[0];
      p.rm = r[1];
      return p;
   endfunction

   // Translation rule, worked out from the entry and the captured request
   function automatic fetch_rsp_t expected_rsp(input tlb_lo_t lo, input tlb_hi_t hi,
                                               input vpn_t v, input psr_t p);
      fetch_rsp_t r;
      logic       hit;
      logic       may_exec;
      hit = lo.v && (lo.tag == v);
      may_exec = p.rm ? hi.rx : hi.ux;
      r.eitm = p.imme && !hit;
      r.eipf = p.imme && hit && !may_exec;
      r.ppn = p.imme ? hi.ppn : v;
      return r;
   endfunction

   task automatic check_rsp(input fetch_rsp_t exp);
      if (rsp.ppn !== exp.ppn)
         stop_on_error($sformatf("Mismatch rsp.ppn expected %h actual %h", exp.ppn, rsp.ppn));
      if (rsp.eitm !== exp.eitm)
         stop_on_error($sformatf("Mismatch rsp.eitm expected %h actual %h", exp.eitm, rsp.eitm));
      if (rsp.eipf !== exp.eipf)
         stop_on_error($sformatf("Mismatch rsp.eipf expected %h actual %h", exp.eipf, rsp.eipf));
   endtask

   task automatic check_ack(input logic exp);
      if (msr_ack !== exp)
         stop_on_error($sformatf("Mismatch msr_ack expected %h actual %h", exp, msr_ack));
   endtask

   // One four-phase register write, random idle gap and req hold
   task automatic write_reg(input msr_op_e op, input idx_t idx, input logic [31:0] data);
      int gap;
      int hold;
      int n;
      gap = $urandom_range(0, 3);
      repeat (gap)
      begin
         @(posedge clk);
         #1;
      end
      check_ack(1'b0);
      msr.op = op;
      msr.idx = idx;
      msr.data = data;
      msr_req = 1'b1;
      n = 0;
      do
      begin
         @(posedge clk);
         #1;
         n++;
      end while (!msr_ack && n < 50);
      if (!msr_ack)
         stop_on_error("msr_ack did not rise within 50 cycles of the request");
      hold = $urandom_range(0, 3);
      repeat (hold)
      begin
         @(posedge clk);
         #1;
         check_ack(1'b1);
      end
      msr_req = 1'b0;
      n = 0;
      do
      begin
         @(posedge clk);
         #1;
         n++;
      end while (msr_ack && n < 50);
      if (msr_ack)
         stop_on_error("msr_ack did not fall within 50 cycles of dropping the request");
      if (op == msr_tlbl)
         lo_m[idx] = tlb_lo_t'(data);
      else
         hi_m[idx] = tlb_hi_t'(data);
      // Junk on the bus while idle must not write anything
      msr.op = msr_op_e'($urandom_range(0, 1));
      msr.idx = idx_t'($urandom_range(0, n_sets - 1));
      msr.data = rand_word();
   endtask

   // Random entry, tag low bits match the index so a hit is possible
   task automatic fill_entry(input idx_t i);
      tlb_lo_t lo;
      tlb_hi_t hi;
      vpn_t    t;
      lo = tlb_lo_t'(rand_word());
      t = rand_vpn();
      lo.tag = {t[vpn_w-1:set_bits], i};
      lo.v = ($urandom_range(0, 3) != 0);
      hi = tlb_hi_t'(rand_word());
      write_reg(msr_tlbl, i, lo);
      write_reg(msr_tlbh, i, hi);
   endtask

   // Lookup, then a random stall with inputs wandering
   task automatic lookup(input vpn_t v, input psr_t p);
      fetch_rsp_t exp;
      int         stall;
      re = 1'b1;
      vpn = v;
      psr = p;
      @(posedge clk);
      #1;
      re = 1'b0;
      exp = expected_rsp(lo_m[v[set_bits-1:0]], hi_m[v[set_bits-1:0]], v, p);
      check_rsp(exp);
      if (!p.imme)
         n_off++;
      else if (exp.eitm)
         n_miss++;
      else if (exp.eipf)
         n_fault++;
      else
         n_hit++;
      stall = $urandom_range(0, 3);
      repeat (stall)
      begin
         vpn = rand_vpn();
         psr = rand_psr();
         @(posedge clk);
         #1;
         check_rsp(exp);
      end
   endtask

   initial
   begin
      idx_t i;
      vpn_t v;
      psr_t p;
      clk = 1'b0;
      reset = 1'b1;
      re = 1'b0;
      vpn = '0;
      psr = '0;
      msr_req = 1'b0;
      msr = '0;
      n_hit = 0;
      n_miss = 0;
      n_fault = 0;
      n_off = 0;
      void'($urandom(79168));
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;
      // Idle port and pass-through response out of reset
      check_ack(1'b0);
      check_rsp('0);
      // Fill every entry, 32 writes
      for (int k = 0; k < n_sets; k++)
         fill_entry(idx_t'(k));
      // Translation on, hits, misses and faults
      repeat (300)
      begin
         i = idx_t'($urandom_range(0, n_sets - 1));
         if ($urandom_range(0, 9) == 0)
            fill_entry(i);
         v = lo_m[i].tag;
         if ($urandom_range(0, 3) == 0)
            v = rand_vpn();
         p = rand_psr();
         p.imme = 1'b1;
         lookup(v, p);
      end
      // Translation off, vpn passes through
      repeat (60)
      begin
         p = rand_psr();
         p.imme = 1'b0;
         lookup(rand_vpn(), p);
      end
      if (n_hit == 0 || n_miss == 0 || n_fault == 0 || n_off == 0)
      begin
         stop_on_error("a translation outcome was never exercised");
      end
      else
      begin
         $display("test passed");
         $finish;
      end
   end

endmodule

/* verilog.f */
design/immu_pkg.sv
design/itlb_ram.sv
design/itlb_msr_port.sv
design/immu.sv
design/immu_top.sv
tb/immu_assert.sv
tb/immu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the instruction MMU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module immu_tb -o immu_sim

# Simulation status is judged from the log
./obj_dir/immu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^test passed$" sim.log; then
   exit 0
else
   exit 1
fi
